//--- hw/deparser.sv
`timescale 1ns/1ps
`default_nettype none

module deparser (
	input wire clk,
	input wire aresetn,
	input wire [rmt_pkg::data_width+rmt_pkg::keep_width:0] pkt_fifo_dout,
	input wire pkt_fifo_empty,
	output logic pkt_fifo_rd_en,
	input wire rmt_pkg::phv_word_u phv_fifo_dout,
	input wire phv_fifo_empty,
	output logic phv_fifo_rd_en,
	output logic [rmt_pkg::data_width-1:0] m_axis_tdata,
	output logic [rmt_pkg::keep_width-1:0] m_axis_tkeep,
	output logic m_axis_tvalid,
	output logic m_axis_tlast,
	input wire m_axis_tready
);

	logic [rmt_pkg::data_width-1:0] pkt_data;
	logic [rmt_pkg::keep_width-1:0] pkt_keep;
	logic pkt_last;
	logic first_r; // next outgoing beat opens a packet
	logic load_ok;
	logic avail;
	logic pop;

	assign {pkt_data, pkt_keep, pkt_last} = pkt_fifo_dout;

	// output register empty or being taken this cycle
	assign load_ok = !m_axis_tvalid || m_axis_tready;
	// a first beat needs its phv as well
	assign avail = !pkt_fifo_empty && (!first_r || !phv_fifo_empty);
	assign pop = load_ok && avail;

	assign pkt_fifo_rd_en = pop;
	assign phv_fifo_rd_en = pop && first_r;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			first_r <= 1'b1;
			m_axis_tvalid <= 1'b0;
		end else if (pop) begin
			first_r <= pkt_last;
			m_axis_tvalid <= 1'b1;
		end else if (m_axis_tready) begin
			m_axis_tvalid <= 1'b0;
		end
	end

	// output beat, phv goes back into the first one
	always_ff @(posedge clk) begin
		if (pop) begin
			m_axis_tdata <= first_r ? phv_fifo_dout.raw : pkt_data;
			m_axis_tkeep <= pkt_keep;
			m_axis_tlast <= pkt_last;
		end
	end

endmodule

`default_nettype wire

//--- hw/match_action_stage.sv
`timescale 1ns/1ps
`default_nettype none

module match_action_stage #(
	parameter int stage_id = 0
) (
	input wire clk,
	input wire aresetn,
	input wire rmt_pkg::phv_word_u phv_in,
	input wire phv_in_valid,
	output logic stage_ready_out,
	output rmt_pkg::phv_word_u phv_out,
	output logic phv_out_valid,
	input wire stage_ready_in
);

	// this stage's table row
	localparam int unsigned key_idx = rmt_table_pkg::key_sel[stage_id];
	localparam int unsigned act_idx = rmt_table_pkg::act_sel[stage_id];
	localparam logic [rmt_pkg::cont_width-1:0] match = rmt_table_pkg::match_val[stage_id];
	localparam logic [rmt_pkg::cont_width-1:0] add = rmt_table_pkg::act_add[stage_id];

	rmt_pkg::phv_word_u phv_next;
	logic hit;
	logic accept;

	assign hit = (phv_in.cont[key_idx] == match);

	always_comb begin
		phv_next = phv_in;
		if (hit)
			phv_next.cont[act_idx] = phv_in.cont[act_idx] + add; // wraps at 16 bits
	end

	// free when empty or when the next stage drains us this cycle
	assign stage_ready_out = !phv_out_valid || stage_ready_in;
	assign accept = phv_in_valid && stage_ready_out;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			phv_out_valid <= 1'b0;
		end else if (accept) begin
			phv_out_valid <= 1'b1;
		end else if (stage_ready_in) begin
			phv_out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			phv_out <= phv_next;
	end

endmodule

`default_nettype wire

//--- hw/pkt_parser.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_parser (
	input wire clk,
	input wire aresetn,
	input wire [rmt_pkg::data_width-1:0] s_axis_tdata,
	input wire [rmt_pkg::keep_width-1:0] s_axis_tkeep,
	input wire s_axis_tvalid,
	input wire s_axis_tlast,
	output logic s_axis_tready,
	input wire pkt_fifo_full,
	input wire stage_ready,
	output logic pkt_wr_en,
	output logic [rmt_pkg::data_width+rmt_pkg::keep_width:0] pkt_wr_data,
	output rmt_pkg::phv_word_u phv_out,
	output logic phv_valid
);

	rmt_pkg::phv_word_u in_word;
	logic run_r; // low during and just after reset
	logic first_r; // next beat opens a packet
	logic drop_r; // decision for the rest of the packet
	logic tag_hit;
	logic keep_pkt;
	logic xfer;

	assign in_word.raw = s_axis_tdata;
	assign tag_hit = (in_word.cont[rmt_pkg::tag_index] == rmt_pkg::accept_tag);
	assign keep_pkt = first_r ? tag_hit : !drop_r;

	// a kept first beat also needs stage 0 free, so a waiting phv blocks it
	assign s_axis_tready = run_r &&
		(!keep_pkt || (!pkt_fifo_full && (!first_r || stage_ready)));
	assign xfer = s_axis_tvalid && s_axis_tready;

	assign pkt_wr_en = xfer && keep_pkt;
	assign pkt_wr_data = {s_axis_tdata, s_axis_tkeep, s_axis_tlast};

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			run_r <= 1'b0;
			first_r <= 1'b1;
			drop_r <= 1'b0;
			phv_valid <= 1'b0;
		end else begin
			run_r <= 1'b1;
			if (xfer) begin
				first_r <= s_axis_tlast;
				if (first_r)
					drop_r <= !tag_hit;
			end
			if (xfer && first_r && tag_hit)
				phv_valid <= 1'b1;
			else if (stage_ready)
				phv_valid <= 1'b0; // taken by stage 0
		end
	end

	// phv payload
	always_ff @(posedge clk) begin
		if (xfer && first_r && tag_hit)
			phv_out <= in_word;
	end

endmodule

`default_nettype wire

//--- hw/rmt_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module rmt_pipeline (
	input wire clk,
	input wire aresetn,
	input wire [rmt_pkg::data_width-1:0] s_axis_tdata,
	input wire [rmt_pkg::keep_width-1:0] s_axis_tkeep,
	input wire s_axis_tvalid,
	input wire s_axis_tlast,
	output logic s_axis_tready,
	output logic [rmt_pkg::data_width-1:0] m_axis_tdata,
	output logic [rmt_pkg::keep_width-1:0] m_axis_tkeep,
	output logic m_axis_tvalid,
	output logic m_axis_tlast,
	input wire m_axis_tready
);

	localparam int beat_w = rmt_pkg::data_width + rmt_pkg::keep_width + 1; // data, keep, last

	// packet fifo
	logic pkt_wr_en;
	logic [beat_w-1:0] pkt_wr_data;
	logic pkt_fifo_full;
	logic pkt_fifo_empty;
	logic pkt_fifo_rd_en;
	logic [beat_w-1:0] pkt_fifo_dout;

	// phv fifo
	logic phv_fifo_full;
	logic phv_fifo_empty;
	logic phv_fifo_rd_en;
	rmt_pkg::phv_word_u phv_fifo_dout;

	// stage chain, entry 0 is the parser output, last entry feeds the phv fifo
	rmt_pkg::phv_word_u stg_phv [rmt_pkg::stage_num+1];
	logic stg_valid [rmt_pkg::stage_num+1];
	logic stg_ready [rmt_pkg::stage_num+1];

	pkt_parser u_parser (
		.clk(clk),
		.aresetn(aresetn),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tkeep(s_axis_tkeep),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tready(s_axis_tready),
		.pkt_fifo_full(pkt_fifo_full),
		.stage_ready(stg_ready[0]),
		.pkt_wr_en(pkt_wr_en),
		.pkt_wr_data(pkt_wr_data),
		.phv_out(stg_phv[0]),
		.phv_valid(stg_valid[0])
	);

	sync_fifo #(.width(beat_w), .depth(rmt_pkg::pkt_fifo_depth)) pkt_fifo (
		.clk(clk), .aresetn(aresetn),
		.wr_en(pkt_wr_en), .din(pkt_wr_data),
		.rd_en(pkt_fifo_rd_en), .dout(pkt_fifo_dout),
		.full(pkt_fifo_full), .empty(pkt_fifo_empty)
	);

	for (genvar i = 0; i < rmt_pkg::stage_num; i++) begin : g_stage
		match_action_stage #(.stage_id(i)) u_stage (
			.clk(clk), .aresetn(aresetn),
			.phv_in(stg_phv[i]), .phv_in_valid(stg_valid[i]),
			.stage_ready_out(stg_ready[i]),
			.phv_out(stg_phv[i+1]), .phv_out_valid(stg_valid[i+1]),
			.stage_ready_in(stg_ready[i+1])
		);
	end

	assign stg_ready[rmt_pkg::stage_num] = !phv_fifo_full; // last stage stalls on a full fifo

	sync_fifo #(.width(rmt_pkg::data_width), .depth(rmt_pkg::phv_fifo_depth)) phv_fifo (
		.clk(clk), .aresetn(aresetn),
		.wr_en(stg_valid[rmt_pkg::stage_num] && !phv_fifo_full),
		.din(stg_phv[rmt_pkg::stage_num]),
		.rd_en(phv_fifo_rd_en), .dout(phv_fifo_dout),
		.full(phv_fifo_full), .empty(phv_fifo_empty)
	);

	deparser u_deparser (
		.clk(clk), .aresetn(aresetn),
		.pkt_fifo_dout(pkt_fifo_dout), .pkt_fifo_empty(pkt_fifo_empty),
		.pkt_fifo_rd_en(pkt_fifo_rd_en),
		.phv_fifo_dout(phv_fifo_dout), .phv_fifo_empty(phv_fifo_empty),
		.phv_fifo_rd_en(phv_fifo_rd_en),
		.m_axis_tdata(m_axis_tdata), .m_axis_tkeep(m_axis_tkeep),
		.m_axis_tvalid(m_axis_tvalid), .m_axis_tlast(m_axis_tlast),
		.m_axis_tready(m_axis_tready)
	);

endmodule

`default_nettype wire

//--- hw/rmt_pkg.sv
`default_nettype none

package rmt_pkg;

	// stream format
	localparam int data_width = 64;
	localparam int keep_width = data_width / 8; // one bit per byte

	// phv layout
	localparam int cont_width = 16;
	localparam int cont_num = data_width / cont_width;
	localparam int tag_index = 3; // top container of the first beat

	// packets with any other tag are dropped
	localparam logic [cont_width-1:0] accept_tag = 16'h0800;

	localparam int stage_num = 5;

	localparam int pkt_fifo_depth = 16; // two max-length packets
	localparam int phv_fifo_depth = 4;

	// first beat of a packet, seen as a stream word or as containers
	// cont[0] sits in the low 16 bits
	typedef union packed {
		logic [data_width-1:0] raw;
		logic [cont_num-1:0][cont_width-1:0] cont;
	} phv_word_u;

endpackage

`default_nettype wire

//--- hw/rmt_table_pkg.sv
`default_nettype none

package rmt_table_pkg;

	// one row per stage, row i belongs to stage i
	// rows chain on purpose: with cont1 = 16'h0100 and cont0 = 16'h0001
	// stages 0, 2, 3 and 4 all hit, each on a value written before it

	// container compared by each stage
	localparam int unsigned key_sel [rmt_pkg::stage_num] = '{0, 1, 1, 2, 0};

	localparam logic [rmt_pkg::cont_width-1:0] match_val [rmt_pkg::stage_num] = '{
		16'h0001,
		16'h0100,
		16'h0123,
		16'h0f00,
		16'h0002
	};

	// container modified on a hit
	localparam int unsigned act_sel [rmt_pkg::stage_num] = '{1, 1, 2, 0, 2};

	localparam logic [rmt_pkg::cont_width-1:0] act_add [rmt_pkg::stage_num] = '{
		16'h0023,
		16'h0001,
		16'h0f00,
		16'h0001,
		16'h0010
	};

endpackage

`default_nettype wire

//--- hw/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int width = 8,
	parameter int depth = 4
) (
	input wire clk,
	input wire aresetn,
	input wire wr_en,
	input wire [width-1:0] din,
	input wire rd_en,
	output logic [width-1:0] dout,
	output logic full,
	output logic empty
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	logic [width-1:0] mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic do_wr;
	logic do_rd;

	assign full = (count == cnt_w'(depth));
	assign empty = (count == '0);
	assign do_wr = wr_en && !full; // write into a full fifo is lost
	assign do_rd = rd_en && !empty;
	assign dout = mem[rd_ptr]; // show-ahead head entry

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // idle or both at once
			endcase
		end
	end

endmodule

`default_nettype wire

//--- tests/rmt_pipeline_sva.sv
`timescale 1ns/1ps
`default_nettype none

module rmt_pipeline_sva (
	input wire clk,
	input wire aresetn,
	input wire s_axis_tready,
	input wire [rmt_pkg::data_width-1:0] m_axis_tdata,
	input wire [rmt_pkg::keep_width-1:0] m_axis_tkeep,
	input wire m_axis_tvalid,
	input wire m_axis_tlast,
	input wire m_axis_tready
);

	a_valid_known: assert property (@(posedge clk) disable iff (!aresetn)
		!$isunknown(m_axis_tvalid))
		else $error("m_axis_tvalid is unknown");

	// a stalled output beat keeps its contents
	a_out_hold: assert property (@(posedge clk) disable iff (!aresetn)
		m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
			&& $stable(m_axis_tkeep) && $stable(m_axis_tlast))
		else $error("output beat changed while stalled");

	a_reset_quiet: assert property (@(posedge clk)
		!aresetn |-> !s_axis_tready && !m_axis_tvalid)
		else $error("stream handshake active during reset");

endmodule

bind rmt_pipeline rmt_pipeline_sva u_sva (
	.clk(clk),
	.aresetn(aresetn),
	.s_axis_tready(s_axis_tready),
	.m_axis_tdata(m_axis_tdata),
	.m_axis_tkeep(m_axis_tkeep),
	.m_axis_tvalid(m_axis_tvalid),
	.m_axis_tlast(m_axis_tlast),
	.m_axis_tready(m_axis_tready)
);

`default_nettype wire

//--- tests/rmt_pipeline_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rmt_pipeline_tb;

	localparam int clk_period_ns = 100;
	localparam int reset_cycles = 8;
	localparam int num_pkts = 80;
	localparam int watchdog_cycles = num_pkts * 200 + 200; // per packet plus margin
	localparam int drain_cycles = 2000; // bound on the wait for the last beats
	localparam int cw = rmt_pkg::cont_width;
	localparam int beat_w = rmt_pkg::data_width + rmt_pkg::keep_width + 1;

	logic clk;
	logic aresetn;
	logic [rmt_pkg::data_width-1:0] s_axis_tdata;
	logic [rmt_pkg::keep_width-1:0] s_axis_tkeep;
	logic s_axis_tvalid;
	logic s_axis_tlast;
	logic s_axis_tready;
	logic [rmt_pkg::data_width-1:0] m_axis_tdata;
	logic [rmt_pkg::keep_width-1:0] m_axis_tkeep;
	logic m_axis_tvalid;
	logic m_axis_tlast;
	logic m_axis_tready;

	logic [beat_w-1:0] exp_q [$]; // {data, keep, last} in output order
	int kept_sent;

	tb_clock_gen #(.period_ns(clk_period_ns)) u_clk (.clk(clk));

	rmt_pipeline DUT (
		.clk(clk), .aresetn(aresetn),
		.s_axis_tdata(s_axis_tdata), .s_axis_tkeep(s_axis_tkeep),
		.s_axis_tvalid(s_axis_tvalid), .s_axis_tlast(s_axis_tlast),
		.s_axis_tready(s_axis_tready),
		.m_axis_tdata(m_axis_tdata), .m_axis_tkeep(m_axis_tkeep),
		.m_axis_tvalid(m_axis_tvalid), .m_axis_tlast(m_axis_tlast),
		.m_axis_tready(m_axis_tready)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected)
			fail_run($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, actual,
				expected));
	endtask

	// five table rows in order where each sees the result of the one before
	function automatic logic [63:0] apply_stages(input logic [63:0] w);
		logic [63:0] r;
		int s;
		int k;
		int a;
		r = w;
		for (s = 0; s < rmt_pkg::stage_num; s++) begin
			k = rmt_table_pkg::key_sel[s];
			a = rmt_table_pkg::act_sel[s];
			if (r[k*cw +: cw] == rmt_table_pkg::match_val[s])
				r[a*cw +: cw] = r[a*cw +: cw] + rmt_table_pkg::act_add[s];
		end
		return r;
	endfunction

	// called right after a falling edge and returns on the falling edge after the handshake
	task automatic drive_beat(input logic [63:0] data, input logic [7:0] keep, input logic last);
		logic taken;
		s_axis_tvalid = 1'b0;
		while ($urandom_range(0, 3) == 0)
			@(negedge clk); // idle gap
		s_axis_tdata = data;
		s_axis_tkeep = keep;
		s_axis_tlast = last;
		s_axis_tvalid = 1'b1;
		do begin
			#10;
			taken = s_axis_tready;
			@(negedge clk);
		end while (!taken);
	endtask

	task automatic send_packet(input int len, input bit keep_it, input bit chain);
		logic [63:0] data;
		logic [7:0] keep;
		logic last;
		int b;
		for (b = 0; b < len; b++) begin
			data = {$urandom, $urandom};
			last = (b == len - 1);
			keep = last ? 8'($urandom_range(1, 255)) : 8'hff;
			if (b == 0) begin
				if (chain) begin
					data[0 +: cw] = $urandom_range(0, 1) ? 16'h0001 : 16'h0002;
					data[cw +: cw] = 16'h0100;
					data[2*cw +: cw] = 16'h0000;
				end
				if (keep_it)
					data[rmt_pkg::tag_index*cw +: cw] = rmt_pkg::accept_tag;
				else if (data[rmt_pkg::tag_index*cw +: cw] == rmt_pkg::accept_tag)
					data[rmt_pkg::tag_index*cw] = ~data[rmt_pkg::tag_index*cw];
				if (keep_it)
					exp_q.push_back({apply_stages(data), keep, last});
			end else if (keep_it) begin
				exp_q.push_back({data, keep, last}); // later beats unchanged
			end
			drive_beat(data, keep, last);
			if (b == 0 && keep_it)
				kept_sent++;
		end
	endtask

	initial begin : stimulus
		int p;
		bit keep_it;
		bit chain;
		int drain;
		aresetn = 1'b0;
		s_axis_tdata = '0;
		s_axis_tkeep = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
		m_axis_tready = 1'b0;
		kept_sent = 0;
		void'($urandom(32'h06e5_4a2d));
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		aresetn = 1'b1;
		for (p = 0; p < num_pkts; p++) begin
			keep_it = (p < 2) ? 1'b0 : ($urandom_range(0, 99) < 70); // open with drops
			chain = ($urandom_range(0, 3) == 0);
			send_packet($urandom_range(1, 8), keep_it, chain);
		end
		s_axis_tvalid = 1'b0;
		drain = 0;
		while (exp_q.size() != 0 && drain < drain_cycles) begin
			@(negedge clk);
			drain++;
		end
		repeat (50) @(negedge clk); // catch stray beats
		if (exp_q.size() == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			fail_run("expected output beats were never seen");
		end
	end

	// random back-pressure and scoreboard sampled well after the falling edge
	initial begin : output_monitor
		logic [beat_w-1:0] e;
		forever begin
			@(negedge clk);
			m_axis_tready = ($urandom_range(0, 9) < 6);
			#10;
			if (aresetn && kept_sent == 0)
				check_value(m_axis_tvalid, 0, "m_axis_tvalid before any kept packet");
			if (m_axis_tvalid && m_axis_tready) begin
				if (exp_q.size() == 0)
					fail_run("an output beat appeared that no kept packet accounts for");
				e = exp_q.pop_front();
				check_value(m_axis_tdata, e[beat_w-1 -: rmt_pkg::data_width], "m_axis_tdata");
				check_value(m_axis_tkeep, e[rmt_pkg::keep_width:1], "m_axis_tkeep");
				check_value(m_axis_tlast, e[0], "m_axis_tlast");
			end
		end
	end

	initial begin : watchdog
		#(watchdog_cycles * clk_period_ns);
		fail_run("watchdog expired, the pipeline stopped moving packets");
	end

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int period_ns = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk; // free running
	end

endmodule

`default_nettype wire

//--- vlog.f
hw/rmt_pkg.sv
hw/rmt_table_pkg.sv
hw/sync_fifo.sv
hw/pkt_parser.sv
hw/match_action_stage.sv
hw/deparser.sv
hw/rmt_pipeline.sv
tests/tb_clock_gen.sv
tests/rmt_pipeline_sva.sv
tests/rmt_pipeline_tb.sv
